// ==== include/fpgc_config.svh ====
// FPGC board I/O configuration
`ifndef FPGC_CONFIG_SVH
`define FPGC_CONFIG_SVH

// Flop rows in the board input synchronizer
`define SYNC_STAGES 2

// Reset pulse length after a rising edge of serial DTR
`define DTR_PULSE_CYCLES 8

// Minimum LED on-time after the last activity
// Scaled down from the board value of 100000
`define LED_MIN_CYCLES 16

// Video RAM geometry
`define VRAM_WORDS 1056
`define VRAM_ADDR_W 11
`define VRAM_DATA_W 32

`endif

// ==== source/fpgc_pkg.sv ====
// FPGC board I/O types
`include "fpgc_config.svh"

package fpgc_pkg;

    // VRAM word and address
    typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;
    typedef logic [`VRAM_DATA_W-1:0] vram_data_t;

    // CPU port opcode with the meaning of bus_we on the CPU bus
    typedef enum logic {
        VRAM_READ  = 1'b0,
        VRAM_WRITE = 1'b1
    } vram_op_t;

    // DTR reset pulse FSM
    typedef enum logic {
        DTR_IDLE  = 1'b0,
        DTR_PULSE = 1'b1
    } dtr_state_t;

    // Activity LED FSM
    typedef enum logic {
        LED_OFF  = 1'b0,
        LED_HOLD = 1'b1
    } led_state_t;

endpackage

// ==== source/input_synchronizer.sv ====
// Board input synchronizer
`timescale 1ns/1ps
`include "fpgc_config.svh"

module input_synchronizer #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] sync_in,
    output logic [WIDTH-1:0] sync_out
);

    localparam int STAGES = `SYNC_STAGES;

    // One row of flops per stage with all bits side by side
    logic [WIDTH-1:0] sync_q [STAGES];

    // Each stage takes the row before it
    always_ff @(posedge clk) begin
        sync_q[0] <= sync_in;
        for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign sync_out = sync_q[STAGES-1];

endmodule

// ==== source/reset_controller.sv ====
// DTR reset pulse and system reset
`timescale 1ns/1ps
`include "fpgc_config.svh"

module reset_controller
    import fpgc_pkg::*;
(
    input  logic clk,
    input  logic rst_n_sync,
    input  logic dtr_sync,
    output logic sys_rst_n,
    output logic ext_reset,
    output logic ext_reset_n
);

    localparam int PULSE_LEN = `DTR_PULSE_CYCLES;
    localparam int CNT_W = $clog2(PULSE_LEN);

    dtr_state_t state;
    logic [CNT_W-1:0] pulse_cnt;
    logic dtr_prev;
    logic dtr_rise;
    logic pulse;

    assign dtr_rise = dtr_sync & ~dtr_prev;

    always_ff @(posedge clk) begin
        // Follows DTR through reset, so a line already high gives no pulse
        dtr_prev <= dtr_sync;
        if (!rst_n_sync) begin
            state <= DTR_IDLE;
            pulse_cnt <= '0;
        end else begin
            case (state)
                DTR_IDLE: begin
                    if (dtr_rise) begin
                        state <= DTR_PULSE;
                        pulse_cnt <= CNT_W'(PULSE_LEN - 1);
                    end
                end
                DTR_PULSE: begin
                    if (pulse_cnt == '0) begin
                        state <= DTR_IDLE;
                    end else begin
                        pulse_cnt <= pulse_cnt - 1'b1;
                    end
                end
                default: state <= DTR_IDLE;
            endcase
        end
    end

    assign pulse = (state == DTR_PULSE);

    // Button reset or serial port open
    assign ext_reset   = pulse | ~rst_n_sync;
    assign ext_reset_n = ~ext_reset;
    assign sys_rst_n   = ~ext_reset;

    a_pulse_len: assert property (@(posedge clk) disable iff (!rst_n_sync)
        $rose(pulse) |-> ##PULSE_LEN !pulse);

endmodule

// ==== source/activity_led.sv ====
// Activity LED stretcher
`timescale 1ns/1ps
`include "fpgc_config.svh"

module activity_led
    import fpgc_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic activity,
    output logic led
);

    localparam int HOLD_LEN = `LED_MIN_CYCLES;
    localparam int HOLD_W = $clog2(HOLD_LEN);

    led_state_t state;
    logic [HOLD_W-1:0] hold_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LED_OFF;
            hold_cnt <= '0;
        end else if (activity) begin
            // Any activity restarts the full on-time
            state <= LED_HOLD;
            hold_cnt <= HOLD_W'(HOLD_LEN - 1);
        end else begin
            case (state)
                LED_HOLD: begin
                    if (hold_cnt == '0) begin
                        state <= LED_OFF;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: state <= LED_OFF;
            endcase
        end
    end

    assign led = (state == LED_HOLD);

    // Outside reset the LED falls only after a full hold time on
    a_led_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(led) && $past(rst_n) |-> $past(led, HOLD_LEN));

endmodule

// ==== source/vram_bank.sv ====
// Dual-port video RAM bank
`timescale 1ns/1ps
`include "fpgc_config.svh"

module vram_bank
    import fpgc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // CPU port with start/done handshake
    input  logic       bus_start,
    input  vram_op_t   bus_op,
    input  vram_addr_t bus_addr,
    input  vram_data_t bus_data,
    output vram_data_t bus_q,
    output logic       bus_done,
    output logic       write_strobe,

    // GPU read port
    input  vram_addr_t gpu_addr,
    output vram_data_t gpu_q
);

    vram_data_t mem [`VRAM_WORDS];
    logic wr_req;

    assign wr_req = bus_start && (bus_op == VRAM_WRITE);

    // Write strobe for the GPU activity LED
    assign write_strobe = wr_req;

    // Done one cycle after every start, so requests can go back to back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_done <= 1'b0;
        end else begin
            bus_done <= bus_start;
        end
    end

    // CPU port drops requests during reset
    always_ff @(posedge clk) begin
        if (rst_n && wr_req) begin
            mem[bus_addr] <= bus_data;
        end
        if (rst_n && bus_start) begin
            bus_q <= mem[bus_addr];
        end
    end

    // GPU port sees the old word on a same-address CPU write
    always_ff @(posedge clk) begin
        gpu_q <= mem[gpu_addr];
    end

    a_bus_addr: assert property (@(posedge clk) disable iff (!rst_n)
        bus_start |-> bus_addr < `VRAM_WORDS);

    a_gpu_addr: assert property (@(posedge clk) disable iff (!rst_n)
        gpu_addr < `VRAM_WORDS);

endmodule

// ==== source/fpgc_io_top.sv ====
// FPGC board I/O top level
`timescale 1ns/1ps

module fpgc_io_top
    import fpgc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Asynchronous board inputs
    input  logic       uart_dtr,
    input  logic       frame_drawn,
    input  logic       boot_mode_sw,

    // USB chip select already on clk
    input  logic       usb_cs_n,

    // CPU bus to the VRAM
    input  logic       bus_start,
    input  vram_op_t   bus_op,
    input  vram_addr_t bus_addr,
    input  vram_data_t bus_data,
    output vram_data_t bus_q,
    output logic       bus_done,

    // GPU read port
    input  vram_addr_t gpu_addr,
    output vram_data_t gpu_q,

    // Status and reset outputs
    output logic       frame_irq,
    output logic       boot_mode,
    output logic       ext_reset,
    output logic       ext_reset_n,
    output logic       serial_led,
    output logic       led_gpu,
    output logic       led_usb
);

    logic [3:0] sync_bus;
    logic rst_n_sync;
    logic dtr_sync;
    logic sys_rst_n;
    logic vram_wr;

    // Bits from 0 up carry reset button, DTR, frame drawn and boot mode switch
    input_synchronizer #(
        .WIDTH(4)
    ) u_input_sync (
        .clk      (clk),
        .sync_in  ({boot_mode_sw, frame_drawn, uart_dtr, rst_n}),
        .sync_out (sync_bus)
    );

    assign rst_n_sync = sync_bus[0];
    assign dtr_sync   = sync_bus[1];
    assign frame_irq  = sync_bus[2];
    assign boot_mode  = sync_bus[3];

    // Lit while the serial port is open
    assign serial_led = dtr_sync;

    reset_controller u_reset_ctrl (
        .clk         (clk),
        .rst_n_sync  (rst_n_sync),
        .dtr_sync    (dtr_sync),
        .sys_rst_n   (sys_rst_n),
        .ext_reset   (ext_reset),
        .ext_reset_n (ext_reset_n)
    );

    vram_bank u_vram (
        .clk          (clk),
        .rst_n        (sys_rst_n),
        .bus_start    (bus_start),
        .bus_op       (bus_op),
        .bus_addr     (bus_addr),
        .bus_data     (bus_data),
        .bus_q        (bus_q),
        .bus_done     (bus_done),
        .write_strobe (vram_wr),
        .gpu_addr     (gpu_addr),
        .gpu_q        (gpu_q)
    );

    activity_led u_led_gpu (
        .clk      (clk),
        .rst_n    (sys_rst_n),
        .activity (vram_wr),
        .led      (led_gpu)
    );

    // Chip select is active low
    activity_led u_led_usb (
        .clk      (clk),
        .rst_n    (sys_rst_n),
        .activity (~usb_cs_n),
        .led      (led_usb)
    );

endmodule

// ==== testbench/tb_fpgc_io_top.sv ====
// FPGC board I/O testbench
`timescale 1ns/1ps
`include "fpgc_config.svh"

module tb_fpgc_io_top
    import fpgc_pkg::*;
();

    // The tests take about a hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic uart_dtr = 1'b0;
    logic frame_drawn = 1'b0;
    logic boot_mode_sw = 1'b0;
    logic usb_cs_n = 1'b1;
    logic bus_start = 1'b0;
    vram_op_t bus_op = VRAM_READ;
    vram_addr_t bus_addr = '0;
    vram_addr_t gpu_addr = '0;
    vram_data_t bus_data = '0;
    vram_data_t bus_q, gpu_q;
    logic bus_done, frame_irq, boot_mode, ext_reset, ext_reset_n;
    logic serial_led, led_gpu, led_usb;

    // Expected VRAM contents from the writes of the tests
    vram_data_t shadow [`VRAM_WORDS];
    int cycle_count = 0;
    int error_count = 0;
    int last_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    fpgc_io_top u_fpgc_io_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic report_value(input string test, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        error_count++;
        $display("Fail %s: %s expected %h, actual %h", test, what, expected, actual);
    endtask

    task automatic end_test(input string test);
        tests_run++;
        if (error_count != last_errors) tests_failed++;
        $display("Test %s finished, %0d errors", test, error_count - last_errors);
        last_errors = error_count;
    endtask

    function automatic vram_addr_t random_addr();
        return vram_addr_t'($urandom_range(`VRAM_WORDS - 1, 0));
    endfunction

    // Single CPU request with done one cycle after the start
    task automatic cpu_access(input string test, input vram_op_t op, input vram_addr_t addr,
                              input vram_data_t data);
        bus_start = 1'b1;
        bus_op = op;
        bus_addr = addr;
        bus_data = data;
        if (op == VRAM_WRITE) shadow[addr] = data;
        tick();
        bus_start = 1'b0;
        if (bus_done !== 1'b1) report_value(test, "bus_done", 1, 32'(bus_done));
        if (op == VRAM_READ && bus_q !== shadow[addr])
            report_value(test, "bus_q", shadow[addr], bus_q);
    endtask

    task automatic reset_state();
        if (ext_reset !== 1'b0) report_value("reset_state", "ext_reset", 0, 32'(ext_reset));
        if (ext_reset_n !== 1'b1)
            report_value("reset_state", "ext_reset_n", 1, 32'(ext_reset_n));
        if (bus_done !== 1'b0) report_value("reset_state", "bus_done", 0, 32'(bus_done));
        if (led_gpu !== 1'b0) report_value("reset_state", "led_gpu", 0, 32'(led_gpu));
        if (led_usb !== 1'b0) report_value("reset_state", "led_usb", 0, 32'(led_usb));
        end_test("reset_state");
    endtask

    task automatic write_read_back();
        vram_addr_t addrs [8];
        // Eight writes and then eight reads with a new start every cycle
        for (int i = 0; i < 16; i++) begin
            if (i < 8) addrs[i] = random_addr();
            bus_start = 1'b1;
            bus_op = (i < 8) ? VRAM_WRITE : VRAM_READ;
            bus_addr = addrs[i % 8];
            bus_data = $urandom();
            if (i < 8) shadow[bus_addr] = bus_data;
            tick();
            if (bus_done !== 1'b1) report_value("write_read", "bus_done", 1, 32'(bus_done));
            if (i >= 8 && bus_q !== shadow[bus_addr])
                report_value("write_read", "bus_q", shadow[bus_addr], bus_q);
        end
        bus_start = 1'b0;
        tick();
        if (bus_done !== 1'b0) report_value("write_read", "idle bus_done", 0, 32'(bus_done));
        end_test("write_read");
    endtask

    task automatic gpu_port_read();
        vram_addr_t addr;
        vram_data_t word;
        addr = random_addr();
        word = $urandom();
        cpu_access("gpu_read", VRAM_WRITE, addr, word);
        gpu_addr = addr;
        tick();
        if (gpu_q !== word) report_value("gpu_read", "gpu_q", word, gpu_q);
        end_test("gpu_read");
    endtask

    task automatic dtr_reset_pulse();
        vram_addr_t addr;
        int high_cycles;
        addr = random_addr();
        high_cycles = 0;
        cpu_access("dtr_pulse", VRAM_WRITE, addr, $urandom());
        uart_dtr = 1'b1;
        repeat (`SYNC_STAGES) tick();
        if (serial_led !== 1'b1) report_value("dtr_pulse", "serial_led", 1, 32'(serial_led));
        if (ext_reset !== 1'b0) report_value("dtr_pulse", "early ext_reset", 0, 32'(ext_reset));
        tick();
        // Bounded so a stuck pulse still ends the loop
        while (ext_reset === 1'b1 && high_cycles <= `DTR_PULSE_CYCLES) begin
            if (ext_reset_n !== 1'b0)
                report_value("dtr_pulse", "ext_reset_n", 0, 32'(ext_reset_n));
            high_cycles++;
            tick();
        end
        if (high_cycles != `DTR_PULSE_CYCLES)
            report_value("dtr_pulse", "ext_reset cycles", `DTR_PULSE_CYCLES, high_cycles);
        uart_dtr = 1'b0;
        repeat (`SYNC_STAGES + 1) tick();
        cpu_access("dtr_pulse", VRAM_READ, addr, '0);
        end_test("dtr_pulse");
    endtask

    task automatic measure_led(input bit use_gpu, output int on_cycles);
        on_cycles = 0;
        while ((use_gpu ? led_gpu : led_usb) === 1'b1 && on_cycles <= `LED_MIN_CYCLES) begin
            on_cycles++;
            tick();
        end
    endtask

    task automatic activity_leds();
        int on_cycles;
        usb_cs_n = 1'b0;
        tick();
        usb_cs_n = 1'b1;
        measure_led(1'b0, on_cycles);
        if (on_cycles != `LED_MIN_CYCLES)
            report_value("activity_leds", "led_usb cycles", `LED_MIN_CYCLES, on_cycles);
        bus_start = 1'b1;
        bus_op = VRAM_WRITE;
        bus_addr = random_addr();
        bus_data = $urandom();
        shadow[bus_addr] = bus_data;
        tick();
        bus_start = 1'b0;
        measure_led(1'b1, on_cycles);
        if (on_cycles != `LED_MIN_CYCLES)
            report_value("activity_leds", "led_gpu cycles", `LED_MIN_CYCLES, on_cycles);
        end_test("activity_leds");
    endtask

    task automatic sync_status();
        logic [1:0] levels;
        // Walks 01, 10, 11 and back to 00
        for (int i = 1; i <= 4; i++) begin
            levels = 2'(i);
            frame_drawn = levels[0];
            boot_mode_sw = levels[1];
            repeat (`SYNC_STAGES) tick();
            if (frame_irq !== levels[0])
                report_value("sync_status", "frame_irq", 32'(levels[0]), 32'(frame_irq));
            if (boot_mode !== levels[1])
                report_value("sync_status", "boot_mode", 32'(levels[1]), 32'(boot_mode));
        end
        end_test("sync_status");
    endtask

    initial begin
        void'($urandom(80232));
        repeat (16) tick();
        rst_n = 1'b1;
        repeat (`SYNC_STAGES + 2) tick();
        reset_state();
        write_read_back();
        gpu_port_read();
        dtr_reset_pulse();
        activity_leds();
        sync_status();
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
source/fpgc_pkg.sv
source/input_synchronizer.sv
source/reset_controller.sv
source/activity_led.sv
source/vram_bank.sv
source/fpgc_io_top.sv
testbench/tb_fpgc_io_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_fpgc_io_top -f filelist.f -o sim_fpgc_io
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/sim_fpgc_io)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
